//--- common/lsq_macros.svh
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// Store queue entries
`define LSQ_STQ_DEPTH 4

// Load table entries
`define LSQ_LDQ_DEPTH 4

// Reorder buffer tag width
`define LSQ_TAG_W 4

// Word index into the scratchpad
`define LSQ_IDX_W 4

`define LSQ_DATA_W 32

// Destination register and immediate offset widths
`define LSQ_RD_W 5
`define LSQ_OFF_W 12

`endif

//--- common/lsq_pkg.sv
`include "lsq_macros.svh"

package lsq_pkg;

  typedef logic [`LSQ_TAG_W-1:0]  tag_t;
  typedef logic [`LSQ_IDX_W-1:0]  idx_t;
  typedef logic [`LSQ_DATA_W-1:0] data_t;
  typedef logic [`LSQ_RD_W-1:0]   rd_t;

  // Load view of the payload word
  typedef struct packed {
    logic [`LSQ_DATA_W-`LSQ_RD_W-1:0] unused;
    rd_t                               rd;
  } ld_view_t;

  // Store data or load destination, picked by is_store
  typedef union packed {
    data_t    st_data;
    ld_view_t ld;
  } lsq_payload_u;

  typedef struct packed {
    logic                         is_store;
    tag_t                         tag;
    logic [`LSQ_DATA_W-1:0]       base;
    logic signed [`LSQ_OFF_W-1:0] offset;
    lsq_payload_u                 payload;
  } mem_op_t;

  typedef struct packed {
    tag_t  tag;
    idx_t  index;
    data_t data;
    logic  committed;
  } stq_entry_t;

  typedef struct packed {
    tag_t tag;
    idx_t index;
    rd_t  rd;
  } ldq_entry_t;

  typedef struct packed {
    idx_t  index;
    data_t data;
  } mem_wr_t;

  typedef struct packed {
    tag_t  tag;
    rd_t   rd;
    data_t data;
    logic  forwarded;
  } wb_pkt_t;

  typedef struct packed {
    logic  hit;
    data_t data;
  } fwd_resp_t;

  // Distance from the oldest in-flight instruction
  function automatic tag_t tag_age(input tag_t tag, input tag_t head);
    return tag - head;
  endfunction

endpackage

//--- lsq/lsq_dispatch.sv
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_dispatch (
  input  logic                clk,
  input  logic                rst,
  input  lsq_pkg::mem_op_t    op,
  input  logic                op_valid,
  output logic                op_ready,
  output lsq_pkg::stq_entry_t stq_push,
  output logic                stq_push_valid,
  input  logic                stq_push_ready,
  output lsq_pkg::ldq_entry_t ldq_push,
  output logic                ldq_push_valid,
  input  logic                ldq_push_ready
);
  import lsq_pkg::*;

  logic                   out_valid;
  logic                   out_is_store;
  logic                   drain;
  logic                   accept;
  logic [`LSQ_DATA_W-1:0] eff_addr;
  idx_t                   word_idx;
  stq_entry_t             stq_reg;
  ldq_entry_t             ldq_reg;

  // Byte address from base plus sign-extended offset
  always_comb begin
    eff_addr = op.base
             + {{(`LSQ_DATA_W-`LSQ_OFF_W){op.offset[`LSQ_OFF_W-1]}}, op.offset};
    // Drop the byte offset within the word
    word_idx = eff_addr[`LSQ_IDX_W+1:2];
  end

  assign drain    = (stq_push_valid && stq_push_ready) || (ldq_push_valid && ldq_push_ready);
  assign op_ready = !out_valid || drain;
  assign accept   = op_valid && op_ready;

  // Output register occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid    <= 1'b0;
      out_is_store <= 1'b0;
    end else if (accept) begin
      out_valid    <= 1'b1;
      out_is_store <= op.is_store;
    end else if (drain) begin
      out_valid <= 1'b0;
    end
  end

  // Payload word decoded by op kind
  always_ff @(posedge clk) begin
    if (accept) begin
      if (op.is_store) begin
        stq_reg.tag       <= op.tag;
        stq_reg.index     <= word_idx;
        stq_reg.data      <= op.payload.st_data;
        stq_reg.committed <= 1'b0;
      end else begin
        ldq_reg.tag   <= op.tag;
        ldq_reg.index <= word_idx;
        ldq_reg.rd    <= op.payload.ld.rd;
      end
    end
  end

  // Only the queue matching the held op sees a valid
  assign stq_push       = stq_reg;
  assign stq_push_valid = out_valid && out_is_store;
  assign ldq_push       = ldq_reg;
  assign ldq_push_valid = out_valid && !out_is_store;

endmodule

//--- lsq/lsq_store_queue.sv
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_store_queue (
  input  logic                clk,
  input  logic                rst,
  input  lsq_pkg::stq_entry_t stq_push,
  input  logic                stq_push_valid,
  output logic                stq_push_ready,
  input  logic                commit_valid,
  input  lsq_pkg::tag_t       rob_head,
  output lsq_pkg::mem_wr_t    mem_wr,
  output logic                mem_wr_valid,
  input  lsq_pkg::idx_t       fwd_index,
  input  lsq_pkg::tag_t       fwd_tag,
  output lsq_pkg::fwd_resp_t  fwd_resp
);
  import lsq_pkg::*;

  localparam int DEPTH = `LSQ_STQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  stq_entry_t       entries [DEPTH];
  stq_entry_t       push_entry;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] commit_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign stq_push_ready = (count != (PTR_W+1)'(DEPTH));
  assign push           = stq_push_valid && stq_push_ready;

  // Committed head goes to the scratchpad and leaves the queue
  assign mem_wr_valid = (count != '0) && entries[rd_ptr].committed;
  assign mem_wr.index = entries[rd_ptr].index;
  assign mem_wr.data  = entries[rd_ptr].data;
  assign pop          = mem_wr_valid;

  // If the head drains this cycle the commit belongs to the next entry
  assign commit_ptr = pop ? ptr_inc(rd_ptr) : rd_ptr;

  always_comb begin
    push_entry           = stq_push;
    push_entry.committed = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= push_entry;
    end
    if (commit_valid) begin
      entries[commit_ptr].committed <= 1'b1;
    end
  end

  // Walk from head to tail so the last match is the youngest
  // Committed entries are older than anything still in flight
  always_comb begin : fwd_search
    tag_t req_age;
    int   slot;
    logic older;
    req_age  = tag_age(fwd_tag, rob_head);
    fwd_resp = '0;
    for (int k = 0; k < DEPTH; k++) begin
      slot  = (int'(rd_ptr) + k) % DEPTH;
      older = entries[slot].committed || (tag_age(entries[slot].tag, rob_head) < req_age);
      if ((k < int'(count)) && (entries[slot].index == fwd_index) && older) begin
        fwd_resp.hit  = 1'b1;
        fwd_resp.data = entries[slot].data;
      end
    end
  end

endmodule

//--- lsq/lsq_load_unit.sv
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_load_unit (
  input  logic                clk,
  input  logic                rst,
  input  lsq_pkg::ldq_entry_t ldq_push,
  input  logic                ldq_push_valid,
  output logic                ldq_push_ready,
  input  lsq_pkg::tag_t       rob_head,
  output lsq_pkg::idx_t       fwd_index,
  output lsq_pkg::tag_t       fwd_tag,
  input  lsq_pkg::fwd_resp_t  fwd_resp,
  output lsq_pkg::idx_t       rd_index,
  output logic                rd_valid,
  input  logic                rd_gnt,
  input  lsq_pkg::data_t      rd_data,
  output lsq_pkg::wb_pkt_t    wb,
  output logic                wb_valid,
  input  logic                wb_ready
);
  import lsq_pkg::*;

  localparam int DEPTH  = `LSQ_LDQ_DEPTH;
  localparam int SLOT_W = $clog2(DEPTH);

  ldq_entry_t        entries [DEPTH];
  logic [DEPTH-1:0]  valid;
  logic [SLOT_W-1:0] sel_slot;
  logic [SLOT_W-1:0] free_slot;
  logic              any_valid;
  logic              has_free;
  logic              push;
  logic              wb_space;
  logic              sel_en;
  logic              fwd_take;
  logic              rd_fire;
  logic              retire;
  logic              pend_valid;
  tag_t              pend_tag;
  rd_t               pend_rd;

  // Oldest valid entry by distance from rob_head
  always_comb begin : pick_oldest
    tag_t best_age;
    sel_slot  = '0;
    any_valid = 1'b0;
    best_age  = '1;
    for (int i = 0; i < DEPTH; i++) begin
      if (valid[i] && (!any_valid || tag_age(entries[i].tag, rob_head) < best_age)) begin
        sel_slot  = SLOT_W'(i);
        best_age  = tag_age(entries[i].tag, rob_head);
        any_valid = 1'b1;
      end
    end
  end

  // Lowest free slot takes the next push
  always_comb begin : pick_free
    free_slot = '0;
    has_free  = 1'b0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_slot = SLOT_W'(i);
        has_free  = 1'b1;
      end
    end
  end

  assign ldq_push_ready = has_free;
  assign push           = ldq_push_valid && has_free;

  // No selection while a read is in flight or the result is stuck
  assign wb_space = !wb_valid || wb_ready;
  assign sel_en   = any_valid && !pend_valid && wb_space;

  assign fwd_index = entries[sel_slot].index;
  assign fwd_tag   = entries[sel_slot].tag;
  assign fwd_take  = sel_en && fwd_resp.hit;

  // Memory path when no older store matches
  assign rd_valid = sel_en && !fwd_resp.hit;
  assign rd_index = entries[sel_slot].index;
  assign rd_fire  = rd_valid && rd_gnt;
  assign retire   = fwd_take || rd_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else begin
      if (retire) begin
        valid[sel_slot] <= 1'b0;
      end
      if (push) begin
        valid[free_slot] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[free_slot] <= ldq_push;
    end
  end

  // Granted read waits one cycle for the scratchpad data
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_valid <= 1'b0;
    end else begin
      pend_valid <= rd_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      pend_tag <= entries[sel_slot].tag;
      pend_rd  <= entries[sel_slot].rd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else if (fwd_take || pend_valid) begin
      wb_valid <= 1'b1;
    end else if (wb_ready) begin
      wb_valid <= 1'b0;
    end
  end

  // Selection is blocked during pend_valid so the two never collide
  always_ff @(posedge clk) begin
    if (fwd_take) begin
      wb.tag       <= entries[sel_slot].tag;
      wb.rd        <= entries[sel_slot].rd;
      wb.data      <= fwd_resp.data;
      wb.forwarded <= 1'b1;
    end else if (pend_valid) begin
      wb.tag       <= pend_tag;
      wb.rd        <= pend_rd;
      wb.data      <= rd_data;
      wb.forwarded <= 1'b0;
    end
  end

endmodule

//--- verilog/lsq_data_mem.sv
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_data_mem (
  input  logic             clk,
  input  logic             rst,
  input  lsq_pkg::mem_wr_t mem_wr,
  input  logic             mem_wr_valid,
  input  lsq_pkg::idx_t    rd_index,
  input  logic             rd_valid,
  output logic             rd_gnt,
  output lsq_pkg::data_t   rd_data
);
  import lsq_pkg::*;

  localparam int WORDS = 1 << `LSQ_IDX_W;

  data_t mem [WORDS];

  // Single port, the store drain always wins
  assign rd_gnt = rd_valid && !mem_wr_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_wr_valid) begin
      mem[mem_wr.index] <= mem_wr.data;
    end
  end

  // Data valid the cycle after grant
  always_ff @(posedge clk) begin
    if (rd_gnt) begin
      rd_data <= mem[rd_index];
    end
  end

endmodule

//--- verilog/lsq_top.sv
`timescale 1ns/1ps

module lsq_top (
  input  logic             clk,
  input  logic             rst,
  input  lsq_pkg::mem_op_t op,
  input  logic             op_valid,
  output logic             op_ready,
  input  logic             commit_valid,
  input  lsq_pkg::tag_t    rob_head,
  output lsq_pkg::wb_pkt_t wb,
  output logic             wb_valid,
  input  logic             wb_ready
);
  import lsq_pkg::*;

  // Dispatch to queues
  stq_entry_t stq_push;
  logic       stq_push_valid;
  logic       stq_push_ready;
  ldq_entry_t ldq_push;
  logic       ldq_push_valid;
  logic       ldq_push_ready;

  // Store drain and forwarding
  mem_wr_t    mem_wr;
  logic       mem_wr_valid;
  idx_t       fwd_index;
  tag_t       fwd_tag;
  fwd_resp_t  fwd_resp;

  // Load read port
  idx_t       rd_index;
  logic       rd_valid;
  logic       rd_gnt;
  data_t      rd_data;

  lsq_dispatch dispatch_i (
    .clk            (clk),
    .rst            (rst),
    .op             (op),
    .op_valid       (op_valid),
    .op_ready       (op_ready),
    .stq_push       (stq_push),
    .stq_push_valid (stq_push_valid),
    .stq_push_ready (stq_push_ready),
    .ldq_push       (ldq_push),
    .ldq_push_valid (ldq_push_valid),
    .ldq_push_ready (ldq_push_ready)
  );

  lsq_store_queue stq_i (
    .clk            (clk),
    .rst            (rst),
    .stq_push       (stq_push),
    .stq_push_valid (stq_push_valid),
    .stq_push_ready (stq_push_ready),
    .commit_valid   (commit_valid),
    .rob_head       (rob_head),
    .mem_wr         (mem_wr),
    .mem_wr_valid   (mem_wr_valid),
    .fwd_index      (fwd_index),
    .fwd_tag        (fwd_tag),
    .fwd_resp       (fwd_resp)
  );

  lsq_load_unit ldu_i (
    .clk            (clk),
    .rst            (rst),
    .ldq_push       (ldq_push),
    .ldq_push_valid (ldq_push_valid),
    .ldq_push_ready (ldq_push_ready),
    .rob_head       (rob_head),
    .fwd_index      (fwd_index),
    .fwd_tag        (fwd_tag),
    .fwd_resp       (fwd_resp),
    .rd_index       (rd_index),
    .rd_valid       (rd_valid),
    .rd_gnt         (rd_gnt),
    .rd_data        (rd_data),
    .wb             (wb),
    .wb_valid       (wb_valid),
    .wb_ready       (wb_ready)
  );

  lsq_data_mem mem_i (
    .clk          (clk),
    .rst          (rst),
    .mem_wr       (mem_wr),
    .mem_wr_valid (mem_wr_valid),
    .rd_index     (rd_index),
    .rd_valid     (rd_valid),
    .rd_gnt       (rd_gnt),
    .rd_data      (rd_data)
  );

endmodule

//--- tb/lsq_assertions.sv
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_assertions (
  input logic             clk,
  input logic             rst,
  input lsq_pkg::wb_pkt_t wb,
  input logic             wb_valid,
  input logic             wb_ready,
  input logic             commit_valid,
  input logic             stq_push_valid,
  input logic             stq_push_ready,
  input logic             ldq_push_valid,
  input logic             ldq_push_ready,
  input logic             ldq_retire,
  input logic             mem_wr_valid
);

  logic stq_push_fire;
  logic ldq_push_fire;
  int   stq_occ;
  int   ldq_occ;
  int   committed_cnt;

  assign stq_push_fire = stq_push_valid && stq_push_ready;
  assign ldq_push_fire = ldq_push_valid && ldq_push_ready;

  // Occupancy and committed stores rebuilt from the handshakes
  always_ff @(posedge clk) begin
    if (rst) begin
      stq_occ       <= 0;
      ldq_occ       <= 0;
      committed_cnt <= 0;
    end else begin
      stq_occ       <= stq_occ + int'(stq_push_fire) - int'(mem_wr_valid);
      ldq_occ       <= ldq_occ + int'(ldq_push_fire) - int'(ldq_retire);
      committed_cnt <= committed_cnt + int'(commit_valid) - int'(mem_wr_valid);
    end
  end

  // Held result may not change until taken
  wb_stable: assert property (@(posedge clk) disable iff (rst)
    wb_valid && !wb_ready |=> wb_valid && $stable(wb))
    else $error("wb changed under stall");

  stq_no_overflow: assert property (@(posedge clk) disable iff (rst)
    stq_push_fire |-> stq_occ < `LSQ_STQ_DEPTH)
    else $error("store queue push while full");

  ldq_no_overflow: assert property (@(posedge clk) disable iff (rst)
    ldq_push_fire |-> ldq_occ < `LSQ_LDQ_DEPTH)
    else $error("load table push while full");

  // Stores drain in order, so a write needs a commit not yet used
  drain_committed: assert property (@(posedge clk) disable iff (rst)
    mem_wr_valid |-> committed_cnt > 0)
    else $error("scratchpad write from uncommitted head");

endmodule

bind lsq_top lsq_assertions asrt_i (
  .clk            (clk),
  .rst            (rst),
  .wb             (wb),
  .wb_valid       (wb_valid),
  .wb_ready       (wb_ready),
  .commit_valid   (commit_valid),
  .stq_push_valid (stq_push_valid),
  .stq_push_ready (stq_push_ready),
  .ldq_push_valid (ldq_push_valid),
  .ldq_push_ready (ldq_push_ready),
  .ldq_retire     (ldu_i.retire),
  .mem_wr_valid   (mem_wr_valid)
);

//--- tb/lsq_tb.sv
`timescale 1ns/1ps
`include "lsq_macros.svh"

module lsq_tb;
  import lsq_pkg::*;

  // Directed phases, the random mix and the final read-back
  localparam int N_OPS      = 2 + 3 + 4 + 16 + 200 + 16;
  localparam int MAX_FLIGHT = 14;

  logic     clk;
  logic     rst;
  mem_op_t  op;
  logic     op_valid;
  logic     op_ready;
  logic     commit_valid;
  tag_t     rob_head;
  wb_pkt_t  wb;
  logic     wb_valid;
  logic     wb_ready;

  // Program-order record of every issued op
  logic        op_store [256];
  idx_t        op_idx   [256];
  data_t       op_data  [256];
  rd_t         op_rd    [256];
  int          op_stord [256];
  logic        op_chk   [256];
  logic        op_fwd   [256];
  logic        done     [256];
  int          tag_seq  [16];
  int          next_seq;
  int          head_seq;
  int          stores_issued;
  int          stores_pushed;
  int          mon_seq;
  logic        hold_commit;
  logic        force_wb_low;
  logic        saw_stall;
  logic [15:0] lfsr_st;
  logic [15:0] rdy_st;

  lsq_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .op_valid     (op_valid),
    .op_ready     (op_ready),
    .commit_valid (commit_valid),
    .rob_head     (rob_head),
    .wb           (wb),
    .wb_valid     (wb_valid),
    .wb_ready     (wb_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v       = {v[30:0], lfsr_st[0]};
      lfsr_st = lfsr_next(lfsr_st);
    end
  endtask

  // Latest earlier store to the same word, else the reset value
  function automatic data_t ref_load(input int seq);
    for (int s = seq - 1; s >= 0; s--) begin
      if (op_store[s] && op_idx[s] == op_idx[seq]) begin
        return op_data[s];
      end
    end
    return '0;
  endfunction

  task automatic fail_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic issue_op(input logic is_st, input idx_t idx, input logic chk,
                          input logic fwd, output int seq);
    logic [31:0] r;
    logic [31:0] target;
    logic [11:0] off;
    while (next_seq - head_seq >= MAX_FLIGHT) begin
      @(posedge clk);
      #1;
    end
    seq = next_seq;
    op_store[seq] = is_st;
    op_idx[seq]   = idx;
    op_chk[seq]   = chk;
    op_fwd[seq]   = fwd;
    done[seq]     = 1'b0;
    rand_bits(32, r);
    op_data[seq]  = r;
    rand_bits(5, r);
    op_rd[seq]    = r[4:0];
    op_stord[seq] = stores_issued;
    if (is_st) begin
      stores_issued++;
    end
    tag_seq[seq % 16] = seq;
    next_seq++;
    // Pick an offset, then solve for the base that lands on idx
    rand_bits(26, r);
    target = {r[25:0], idx, 2'b00};
    rand_bits(10, r);
    off = {r[9:0], 2'b00};
    op.is_store = is_st;
    op.tag      = tag_t'(seq);
    op.offset   = off;
    op.base     = target - {{20{off[11]}}, off};
    if (is_st) begin
      op.payload.st_data = op_data[seq];
    end else begin
      op.payload.ld = '{unused: '0, rd: op_rd[seq]};
    end
    op_valid = 1'b1;
    @(posedge clk);
    while (!op_ready) begin
      @(posedge clk);
    end
    #1;
    op_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (head_seq != next_seq) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Comparison process, all values sampled before the edge updates
  always @(posedge clk) begin
    if (!rst) begin
      if (dut_i.stq_push_valid && dut_i.stq_push_ready) begin
        stores_pushed++;
      end
      if (force_wb_low && op_valid && !op_ready) begin
        saw_stall = 1'b1;
      end
      if (wb_valid && wb_ready) begin
        mon_seq = tag_seq[wb.tag];
        if (mon_seq >= next_seq || op_store[mon_seq] || done[mon_seq]) begin
          fail_run("writeback for a tag with no pending load");
        end
        check_eq("wb.data", wb.data, ref_load(mon_seq));
        check_eq("wb.rd", wb.rd, op_rd[mon_seq]);
        if (op_chk[mon_seq]) begin
          check_eq("wb.forwarded", wb.forwarded, op_fwd[mon_seq]);
        end
        done[mon_seq] = 1'b1;
      end
    end
  end

  // Reorder buffer model: head tag, commits and wb back-pressure
  initial begin
    @(negedge rst);
    forever begin
      @(posedge clk);
      #1;
      while (head_seq < next_seq && done[head_seq]) begin
        head_seq++;
      end
      rob_head     = (head_seq == next_seq) ? tag_t'(next_seq) : tag_t'(head_seq);
      commit_valid = 1'b0;
      if (!hold_commit && head_seq < next_seq && op_store[head_seq]
          && op_stord[head_seq] < stores_pushed) begin
        commit_valid   = 1'b1;
        done[head_seq] = 1'b1;
      end
      rdy_st   = lfsr_next(lfsr_next(rdy_st));
      wb_ready = !force_wb_low && (rdy_st[0] || rdy_st[1]);
    end
  end

  initial begin
    repeat (N_OPS * 40) @(posedge clk);
    fail_run("timeout, operations did not complete");
  end

  initial begin
    int          s;
    int          ld1;
    logic [31:0] r;
    clk = 1'b0;
    rst = 1'b1;
    op = '0;
    op_valid = 1'b0;
    commit_valid = 1'b0;
    rob_head = '0;
    wb_ready = 1'b0;
    next_seq = 0;
    head_seq = 0;
    stores_issued = 0;
    stores_pushed = 0;
    hold_commit = 1'b0;
    force_wb_low = 1'b0;
    saw_stall = 1'b0;
    lfsr_st = 16'd97;
    rdy_st = 16'd97;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check_eq("op_ready", op_ready, 1);
    check_eq("wb_valid", wb_valid, 0);

    // Uncommitted store forwards to the younger load
    hold_commit = 1'b1;
    issue_op(1'b1, 4'd3, 1'b0, 1'b0, s);
    issue_op(1'b0, 4'd3, 1'b1, 1'b1, ld1);
    while (!done[ld1]) begin
      @(posedge clk);
      #1;
    end
    hold_commit = 1'b0;
    wait_idle();

    // Drained store is read back from the scratchpad
    issue_op(1'b1, 4'd5, 1'b0, 1'b0, s);
    wait_idle();
    repeat (2) @(posedge clk);
    #1;
    issue_op(1'b0, 4'd5, 1'b1, 1'b0, s);
    issue_op(1'b0, 4'd15, 1'b0, 1'b0, s);
    wait_idle();

    // Two stores to one word with loads in between
    issue_op(1'b1, 4'd9, 1'b0, 1'b0, s);
    issue_op(1'b0, 4'd9, 1'b0, 1'b0, s);
    issue_op(1'b1, 4'd9, 1'b0, 1'b0, s);
    issue_op(1'b0, 4'd9, 1'b0, 1'b0, s);
    wait_idle();

    // Stream under a long wb stall
    force_wb_low = 1'b1;
    fork
      for (int i = 0; i < 16; i++) begin
        issue_op(i % 3 == 0, idx_t'(i % 4), 1'b0, 1'b0, s);
      end
      begin
        repeat (60) @(posedge clk);
        #1;
        force_wb_low = 1'b0;
      end
    join
    wait_idle();
    check_eq("saw_stall", saw_stall, 1);

    for (int i = 0; i < 200; i++) begin
      rand_bits(5, r);
      issue_op(r[0], idx_t'(r[4:1]), 1'b0, 1'b0, s);
    end
    wait_idle();

    // Every word once more after the final commits
    for (int i = 0; i < (1 << `LSQ_IDX_W); i++) begin
      issue_op(1'b0, idx_t'(i), 1'b0, 1'b0, s);
    end
    wait_idle();
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- sim.f
+incdir+common
common/lsq_pkg.sv
lsq/lsq_dispatch.sv
lsq/lsq_store_queue.sv
lsq/lsq_load_unit.sv
verilog/lsq_data_mem.sv
verilog/lsq_top.sv
tb/lsq_assertions.sv
tb/lsq_tb.sv

//--- Bender.yml
package:
  name: lsq

sources:
  - include_dirs:
      - common
    files:
      - common/lsq_pkg.sv
      - lsq/lsq_dispatch.sv
      - lsq/lsq_store_queue.sv
      - lsq/lsq_load_unit.sv
      - verilog/lsq_data_mem.sv
      - verilog/lsq_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - tb/lsq_assertions.sv
      - tb/lsq_tb.sv
